// File: src/core_pkg.sv
package core_pkg;

localparam int WORD_SIZE      = 32;
localparam int REG_SIZE       = 5;
localparam int SHAMT_SIZE     = 5;
localparam int DMEM_WORDS     = 64;
localparam int DMEM_ADDR_SIZE = $clog2(DMEM_WORDS);

// addi x0, x0, 0
localparam logic [WORD_SIZE-1:0] NOP = 32'h0000_0013;

typedef enum logic [6:0] {
    OPCODE_LUI    = 7'b0110111,
    OPCODE_AUIPC  = 7'b0010111,
    OPCODE_OP     = 7'b0110011,
    OPCODE_OP_IMM = 7'b0010011,
    OPCODE_LOAD   = 7'b0000011,
    OPCODE_STORE  = 7'b0100011
} opcode_e;

typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B
} alu_opcode_e;

typedef enum logic [1:0] {
    NO_BYPASS,
    BY_EX_ID,
    BY_RES_ID
} bypass_e;

typedef struct packed {
    logic [WORD_SIZE-1:0] ex_data;
    logic [WORD_SIZE-1:0] res_data;
} bypass_data_t;

// Destination info of the instruction sitting in execute
typedef struct packed {
    logic                rf_we;
    logic [REG_SIZE-1:0] rf_waddr;
    logic                load;
} ex_info_t;

typedef struct packed {
    alu_opcode_e          alu_opcode;
    logic [WORD_SIZE-1:0] alu_src_a;
    logic [WORD_SIZE-1:0] alu_src_b;
    logic                 rf_we;
    logic [REG_SIZE-1:0]  rf_waddr;
    logic                 memop_rd;
    logic                 memop_wr;
    logic [WORD_SIZE-1:0] store_data;
} id_ex_t;

typedef struct packed {
    logic [WORD_SIZE-1:0] alu_result;
    logic                 rf_we;
    logic [REG_SIZE-1:0]  rf_waddr;
    logic                 memop_rd;
    logic                 memop_wr;
    logic [WORD_SIZE-1:0] store_data;
} ex_mem_t;

endpackage

// File: src/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder import core_pkg::*; (
    input  logic [WORD_SIZE-1:0] instr_i,
    output opcode_e              opcode_o,
    output alu_opcode_e          alu_opcode_o,
    output logic [REG_SIZE-1:0]  raddr_a_o,
    output logic [REG_SIZE-1:0]  raddr_b_o,
    output logic [REG_SIZE-1:0]  waddr_o,
    output logic                 rf_we_o,
    output logic                 use_a_o,
    output logic                 use_b_o,
    output logic                 src_a_pc_o,
    output logic                 src_b_imm_o,
    output logic [WORD_SIZE-1:0] imm_o,
    output logic                 memop_rd_o,
    output logic                 memop_wr_o
);

logic                 legal;
logic [WORD_SIZE-1:0] instr;
logic [2:0]           funct3;
logic [6:0]           funct7;
logic                 rd_nz;

function automatic alu_opcode_e alu_op(input logic [2:0] f3, input logic alt);
    case (f3)
        3'b000:  return alt ? ALU_SUB : ALU_ADD;
        3'b001:  return ALU_SLL;
        3'b010:  return ALU_SLT;
        3'b011:  return ALU_SLTU;
        3'b100:  return ALU_XOR;
        3'b101:  return alt ? ALU_SRA : ALU_SRL;
        3'b110:  return ALU_OR;
        default: return ALU_AND;
    endcase
endfunction

// Anything outside the supported subset becomes the canonical NOP
always_comb begin
    case (instr_i[6:0])
        OPCODE_LUI, OPCODE_AUIPC: legal = 1'b1;
        OPCODE_OP:
            legal = (instr_i[31:25] == 7'h00) ||
                    (instr_i[31:25] == 7'h20 &&
                     (instr_i[14:12] == 3'b000 || instr_i[14:12] == 3'b101));
        OPCODE_OP_IMM: begin
            if (instr_i[14:12] == 3'b001)
                legal = instr_i[31:25] == 7'h00;
            else if (instr_i[14:12] == 3'b101)
                legal = instr_i[31:25] == 7'h00 || instr_i[31:25] == 7'h20;
            else
                legal = 1'b1;
        end
        OPCODE_LOAD, OPCODE_STORE: legal = instr_i[14:12] == 3'b010;
        default: legal = 1'b0;
    endcase
end

assign instr  = legal ? instr_i : NOP;
assign funct3 = instr[14:12];
assign funct7 = instr[31:25];
assign rd_nz  = |instr[11:7];

assign opcode_o  = opcode_e'(instr[6:0]);
assign raddr_a_o = instr[19:15];
assign raddr_b_o = instr[24:20];
assign waddr_o   = instr[11:7];

always_comb begin
    alu_opcode_o = ALU_ADD;
    rf_we_o      = 1'b0;
    use_a_o      = 1'b0;
    use_b_o      = 1'b0;
    src_a_pc_o   = 1'b0;
    src_b_imm_o  = 1'b1;
    imm_o        = {{20{instr[31]}}, instr[31:20]};
    memop_rd_o   = 1'b0;
    memop_wr_o   = 1'b0;

    case (opcode_o)
        OPCODE_LUI: begin
            alu_opcode_o = ALU_PASS_B;
            imm_o        = {instr[31:12], 12'b0};
            rf_we_o      = rd_nz;
        end
        OPCODE_AUIPC: begin
            src_a_pc_o = 1'b1;
            imm_o      = {instr[31:12], 12'b0};
            rf_we_o    = rd_nz;
        end
        OPCODE_OP: begin
            alu_opcode_o = alu_op(funct3, funct7[5]);
            use_a_o      = 1'b1;
            use_b_o      = 1'b1;
            src_b_imm_o  = 1'b0;
            rf_we_o      = rd_nz;
        end
        OPCODE_OP_IMM: begin
            // Only SRAI uses bit 30 of the immediate as a selector
            alu_opcode_o = alu_op(funct3, funct3 == 3'b101 && funct7[5]);
            use_a_o      = 1'b1;
            rf_we_o      = rd_nz;
        end
        OPCODE_LOAD: begin
            use_a_o    = 1'b1;
            memop_rd_o = 1'b1;
            rf_we_o    = rd_nz;
        end
        OPCODE_STORE: begin
            use_a_o    = 1'b1;
            use_b_o    = 1'b1;
            imm_o      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            memop_wr_o = 1'b1;
        end
        default: ;
    endcase
end

endmodule

// File: src/bypass_controller.sv
`timescale 1ns/10ps

module bypass_controller import core_pkg::*; (
    input  logic [REG_SIZE-1:0] src_a_i,
    input  logic [REG_SIZE-1:0] src_b_i,
    input  logic                use_a_i,
    input  logic                use_b_i,
    input  logic [REG_SIZE-1:0] ex_waddr_i,
    input  logic                ex_we_i,
    input  logic                ex_load_i,
    input  logic [REG_SIZE-1:0] res_waddr_i,
    input  logic                res_we_i,
    output bypass_e             bypass_a_o,
    output bypass_e             bypass_b_o,
    output logic                load_use_o
);

function automatic bypass_e select_path(
    input logic [REG_SIZE-1:0] src,
    input logic                used,
    input logic [REG_SIZE-1:0] ex_waddr,
    input logic                ex_we,
    input logic [REG_SIZE-1:0] res_waddr,
    input logic                res_we
);
    if (!used || src == '0)
        return NO_BYPASS;
    // Youngest producer wins
    if (ex_we && ex_waddr == src)
        return BY_EX_ID;
    if (res_we && res_waddr == src)
        return BY_RES_ID;
    return NO_BYPASS;
endfunction

assign bypass_a_o = select_path(src_a_i, use_a_i, ex_waddr_i, ex_we_i, res_waddr_i, res_we_i);
assign bypass_b_o = select_path(src_b_i, use_b_i, ex_waddr_i, ex_we_i, res_waddr_i, res_we_i);

// Load data is not ready in execute, stall one cycle and pick it up from result
assign load_use_o = ex_load_i && (bypass_a_o == BY_EX_ID || bypass_b_o == BY_EX_ID);

endmodule

// File: src/decode_stage.sv
`timescale 1ns/10ps

module decode_stage import core_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic [WORD_SIZE-1:0] instr_i,
    input  logic [WORD_SIZE-1:0] pc_i,
    input  logic [WORD_SIZE-1:0] rf_data_a_i,
    input  logic [WORD_SIZE-1:0] rf_data_b_i,
    input  bypass_data_t         bypass_data_i,
    input  ex_info_t             ex_info_i,
    input  logic [REG_SIZE-1:0]  res_waddr_i,
    input  logic                 res_we_i,
    output logic [REG_SIZE-1:0]  rf_raddr_a_o,
    output logic [REG_SIZE-1:0]  rf_raddr_b_o,
    output logic                 hazard_o,
    output id_ex_t               id_ex_o
);

opcode_e              opcode;
alu_opcode_e          alu_opcode;
logic [REG_SIZE-1:0]  waddr;
logic                 rf_we;
logic                 use_a;
logic                 use_b;
logic                 src_a_pc;
logic                 src_b_imm;
logic [WORD_SIZE-1:0] imm;
logic                 memop_rd;
logic                 memop_wr;
bypass_e              bypass_a;
bypass_e              bypass_b;
logic [WORD_SIZE-1:0] data_a;
logic [WORD_SIZE-1:0] data_b;
logic [WORD_SIZE-1:0] alu_src_a;
id_ex_t               id_ex_d;

function automatic logic [WORD_SIZE-1:0] operand(
    input bypass_e              sel,
    input logic [WORD_SIZE-1:0] rf_data,
    input bypass_data_t         fwd
);
    case (sel)
        BY_EX_ID:  return fwd.ex_data;
        BY_RES_ID: return fwd.res_data;
        default:   return rf_data;
    endcase
endfunction

instr_decoder decoder_i (
    .instr_i      (instr_i),
    .opcode_o     (opcode),
    .alu_opcode_o (alu_opcode),
    .raddr_a_o    (rf_raddr_a_o),
    .raddr_b_o    (rf_raddr_b_o),
    .waddr_o      (waddr),
    .rf_we_o      (rf_we),
    .use_a_o      (use_a),
    .use_b_o      (use_b),
    .src_a_pc_o   (src_a_pc),
    .src_b_imm_o  (src_b_imm),
    .imm_o        (imm),
    .memop_rd_o   (memop_rd),
    .memop_wr_o   (memop_wr)
);

bypass_controller bypass_i (
    .src_a_i     (rf_raddr_a_o),
    .src_b_i     (rf_raddr_b_o),
    .use_a_i     (use_a),
    .use_b_i     (use_b),
    .ex_waddr_i  (ex_info_i.rf_waddr),
    .ex_we_i     (ex_info_i.rf_we),
    .ex_load_i   (ex_info_i.load),
    .res_waddr_i (res_waddr_i),
    .res_we_i    (res_we_i),
    .bypass_a_o  (bypass_a),
    .bypass_b_o  (bypass_b),
    .load_use_o  (hazard_o)
);

assign data_a = operand(bypass_a, rf_data_a_i, bypass_data_i);
assign data_b = operand(bypass_b, rf_data_b_i, bypass_data_i);

always_comb begin
    if (opcode == OPCODE_LUI)
        alu_src_a = '0;
    else if (src_a_pc)
        alu_src_a = pc_i;
    else
        alu_src_a = data_a;
end

always_comb begin
    id_ex_d.alu_opcode = alu_opcode;
    id_ex_d.alu_src_a  = alu_src_a;
    id_ex_d.alu_src_b  = src_b_imm ? imm : data_b;
    id_ex_d.rf_we      = rf_we;
    id_ex_d.rf_waddr   = waddr;
    id_ex_d.memop_rd   = memop_rd;
    id_ex_d.memop_wr   = memop_wr;
    id_ex_d.store_data = data_b;
end

// Bubble on reset or load-use, payload left as is
always_ff @(posedge clk_i) begin
    if (rst_i || hazard_o) begin
        id_ex_o.rf_we    <= 1'b0;
        id_ex_o.memop_rd <= 1'b0;
        id_ex_o.memop_wr <= 1'b0;
    end else begin
        id_ex_o <= id_ex_d;
    end
end

endmodule

// File: src/execute_stage.sv
`timescale 1ns/10ps

module execute_stage import core_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  id_ex_t               id_ex_i,
    output logic [WORD_SIZE-1:0] ex_data_o,
    output ex_mem_t              ex_mem_o
);

logic [WORD_SIZE-1:0]  src_a;
logic [WORD_SIZE-1:0]  src_b;
logic [SHAMT_SIZE-1:0] shamt;
logic [WORD_SIZE-1:0]  alu_result;

assign src_a = id_ex_i.alu_src_a;
assign src_b = id_ex_i.alu_src_b;
assign shamt = src_b[SHAMT_SIZE-1:0];

always_comb begin
    case (id_ex_i.alu_opcode)
        ALU_ADD:    alu_result = src_a + src_b;
        ALU_SUB:    alu_result = src_a - src_b;
        ALU_AND:    alu_result = src_a & src_b;
        ALU_OR:     alu_result = src_a | src_b;
        ALU_XOR:    alu_result = src_a ^ src_b;
        ALU_SLT:    alu_result = {{(WORD_SIZE-1){1'b0}}, $signed(src_a) < $signed(src_b)};
        ALU_SLTU:   alu_result = {{(WORD_SIZE-1){1'b0}}, src_a < src_b};
        ALU_SLL:    alu_result = src_a << shamt;
        ALU_SRL:    alu_result = src_a >> shamt;
        ALU_SRA:    alu_result = $unsigned($signed(src_a) >>> shamt);
        ALU_PASS_B: alu_result = src_b;
        default:    alu_result = src_a + src_b;
    endcase
end

// Forwarded to decode in the same cycle
assign ex_data_o = alu_result;

always_ff @(posedge clk_i) begin
    if (rst_i) begin
        ex_mem_o.rf_we    <= 1'b0;
        ex_mem_o.memop_rd <= 1'b0;
        ex_mem_o.memop_wr <= 1'b0;
    end else begin
        ex_mem_o.alu_result <= alu_result;
        ex_mem_o.rf_we      <= id_ex_i.rf_we;
        ex_mem_o.rf_waddr   <= id_ex_i.rf_waddr;
        ex_mem_o.memop_rd   <= id_ex_i.memop_rd;
        ex_mem_o.memop_wr   <= id_ex_i.memop_wr;
        ex_mem_o.store_data <= id_ex_i.store_data;
    end
end

endmodule

// File: src/result_stage.sv
`timescale 1ns/10ps

module result_stage import core_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  ex_mem_t              ex_mem_i,
    output logic                 wb_we_o,
    output logic [REG_SIZE-1:0]  wb_addr_o,
    output logic [WORD_SIZE-1:0] wb_data_o
);

logic [WORD_SIZE-1:0]      dmem [DMEM_WORDS];
logic [DMEM_ADDR_SIZE-1:0] word_addr;
logic [WORD_SIZE-1:0]      load_data;

// Word aligned, upper address bits ignored
assign word_addr = ex_mem_i.alu_result[DMEM_ADDR_SIZE+1:2];
assign load_data = dmem[word_addr];

always_ff @(posedge clk_i) begin
    if (rst_i) begin
        for (int i = 0; i < DMEM_WORDS; i++)
            dmem[i] <= '0;
    end else if (ex_mem_i.memop_wr) begin
        dmem[word_addr] <= ex_mem_i.store_data;
    end
end

assign wb_we_o   = ex_mem_i.rf_we;
assign wb_addr_o = ex_mem_i.rf_waddr;
assign wb_data_o = ex_mem_i.memop_rd ? load_data : ex_mem_i.alu_result;

endmodule

// File: src/reg_file.sv
`timescale 1ns/10ps

module reg_file import core_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic [REG_SIZE-1:0]  raddr_a_i,
    input  logic [REG_SIZE-1:0]  raddr_b_i,
    input  logic                 we_i,
    input  logic [REG_SIZE-1:0]  waddr_i,
    input  logic [WORD_SIZE-1:0] wdata_i,
    output logic [WORD_SIZE-1:0] rdata_a_o,
    output logic [WORD_SIZE-1:0] rdata_b_o
);

logic [WORD_SIZE-1:0] regs [2**REG_SIZE];

// x0 is never written so it stays zero after reset
always_ff @(posedge clk_i) begin
    if (rst_i) begin
        for (int i = 0; i < 2**REG_SIZE; i++)
            regs[i] <= '0;
    end else if (we_i && waddr_i != '0) begin
        regs[waddr_i] <= wdata_i;
    end
end

assign rdata_a_o = regs[raddr_a_i];
assign rdata_b_o = regs[raddr_b_i];

endmodule

// File: src/core_slice.sv
`timescale 1ns/10ps

module core_slice import core_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic [WORD_SIZE-1:0] instr_i,
    input  logic [WORD_SIZE-1:0] pc_i,
    output logic                 hazard_o,
    output logic                 wb_we_o,
    output logic [REG_SIZE-1:0]  wb_addr_o,
    output logic [WORD_SIZE-1:0] wb_data_o
);

logic [REG_SIZE-1:0]  rf_raddr_a;
logic [REG_SIZE-1:0]  rf_raddr_b;
logic [WORD_SIZE-1:0] rf_data_a;
logic [WORD_SIZE-1:0] rf_data_b;
logic [WORD_SIZE-1:0] ex_data;
bypass_data_t         bypass_data;
ex_info_t             ex_info;
id_ex_t               id_ex;
ex_mem_t              ex_mem;

assign bypass_data = '{ex_data: ex_data, res_data: wb_data_o};
assign ex_info     = '{rf_we: id_ex.rf_we, rf_waddr: id_ex.rf_waddr, load: id_ex.memop_rd};

decode_stage decode_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .rf_data_a_i   (rf_data_a),
    .rf_data_b_i   (rf_data_b),
    .bypass_data_i (bypass_data),
    .ex_info_i     (ex_info),
    .res_waddr_i   (wb_addr_o),
    .res_we_i      (wb_we_o),
    .rf_raddr_a_o  (rf_raddr_a),
    .rf_raddr_b_o  (rf_raddr_b),
    .hazard_o      (hazard_o),
    .id_ex_o       (id_ex)
);

execute_stage execute_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .id_ex_i   (id_ex),
    .ex_data_o (ex_data),
    .ex_mem_o  (ex_mem)
);

result_stage result_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .ex_mem_i  (ex_mem),
    .wb_we_o   (wb_we_o),
    .wb_addr_o (wb_addr_o),
    .wb_data_o (wb_data_o)
);

reg_file reg_file_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .we_i      (wb_we_o),
    .waddr_i   (wb_addr_o),
    .wdata_i   (wb_data_o),
    .rdata_a_o (rf_data_a),
    .rdata_b_o (rf_data_b)
);

endmodule

// File: verif/core_slice_tb.sv
`timescale 1ns/10ps

module core_slice_tb;

logic        clk_i = 1'b0;
logic        rst_i;
logic [31:0] instr_i;
logic [31:0] pc_i;
logic        hazard_o;
logic        wb_we_o;
logic [4:0]  wb_addr_o;
logic [31:0] wb_data_o;

// Program table
string       entry_name[$];
logic [31:0] prog[$];

// ISA-level model state and expected write-backs
logic [31:0] model_regs [32];
logic [31:0] model_mem [64];
logic [4:0]  exp_addr[$];
logic [31:0] exp_data[$];

logic [31:0] lfsr_state = 32'h0c5fcff3;
logic [31:0] pc;
logic [4:0]  load_rd;
int          cycle_count = 0;
int          cycle_limit = 1000000;
int          check_count = 0;
int          error_count = 0;
int          test_checks = 0;
int          test_errors = 0;

core_slice core_slice_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .instr_i   (instr_i),
    .pc_i      (pc_i),
    .hazard_o  (hazard_o),
    .wb_we_o   (wb_we_o),
    .wb_addr_o (wb_addr_o),
    .wb_data_o (wb_data_o)
);

always #2 clk_i = ~clk_i;

function automatic logic [31:0] r_type(input int f7, input int f3, input int rd,
                                       input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
endfunction

function automatic logic [31:0] i_type(input int opc, input int f3, input int rd,
                                       input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
endfunction

function automatic logic [31:0] s_type(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
endfunction

function automatic logic [31:0] u_type(input int opc, input int rd, input int imm);
    return {imm[19:0], rd[4:0], opc[6:0]};
endfunction

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_state[0]};
        lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
endfunction

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3:    return (a < b) ? 32'd1 : 32'd0;
        3'd4:    return a ^ b;
        3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

// True when the instruction reads register r as a source
function automatic logic reads_reg(input logic [31:0] ins, input logic [4:0] r);
    logic two_src;
    logic one_src;
    two_src = ins[6:0] == 7'h33 || ins[6:0] == 7'h23;
    one_src = ins[6:0] == 7'h13 || ins[6:0] == 7'h03;
    if (r == 5'd0)
        return 1'b0;
    return ((two_src || one_src) && ins[19:15] == r) || (two_src && ins[24:20] == r);
endfunction

task automatic model_exec(input logic [31:0] ins, input logic [31:0] at_pc);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] addr;
    logic [31:0] res;
    logic        wr;
    a     = model_regs[ins[19:15]];
    b     = model_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    res   = '0;
    wr    = 1'b1;
    case (ins[6:0])
        7'h37: res = {ins[31:12], 12'b0};
        7'h17: res = at_pc + {ins[31:12], 12'b0};
        7'h33: res = alu_ref(ins[14:12], ins[30], a, b);
        7'h13: res = alu_ref(ins[14:12], ins[14:12] == 3'd5 && ins[30], a, imm_i);
        7'h03: begin
            addr = a + imm_i;
            res  = model_mem[addr[7:2]];
        end
        7'h23: begin
            addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            model_mem[addr[7:2]] = b;
            wr = 1'b0;
        end
        default: wr = 1'b0;
    endcase
    if (wr && ins[11:7] != 5'd0) begin
        model_regs[ins[11:7]] = res;
        exp_addr.push_back(ins[11:7]);
        exp_data.push_back(res);
    end
endtask

task automatic add_entry(input string name, input logic [31:0] ins);
    entry_name.push_back(name);
    prog.push_back(ins);
endtask

task automatic build_program();
    int kind;
    int rd;
    int rs1;
    int rs2;
    int f3;
    int imm;
    int alt;
    add_entry("imm", u_type('h37, 1, 'h12345));
    add_entry("imm", u_type('h17, 2, 'h00010));
    add_entry("imm", i_type('h13, 0, 3, 0, -5));
    add_entry("imm", i_type('h13, 2, 4, 3, -4));
    add_entry("imm", i_type('h13, 3, 5, 3, 5));
    add_entry("imm", i_type('h13, 4, 6, 3, 'h7ff));
    add_entry("imm", i_type('h13, 6, 7, 1, 'h0f0));
    add_entry("imm", i_type('h13, 7, 8, 3, 'h0ff));
    add_entry("imm", i_type('h13, 1, 9, 3, 4));
    add_entry("imm", i_type('h13, 5, 10, 3, 28));
    add_entry("imm", i_type('h13, 5, 11, 3, 'h401));
    // Back-to-back chain through the execute forward path
    add_entry("op", r_type('h00, 0, 12, 1, 3));
    add_entry("op", r_type('h20, 0, 13, 12, 1));
    add_entry("op", r_type('h00, 7, 14, 13, 6));
    add_entry("op", r_type('h00, 6, 15, 14, 1));
    add_entry("op", r_type('h00, 4, 16, 15, 3));
    add_entry("op", r_type('h00, 2, 17, 3, 16));
    add_entry("op", r_type('h00, 3, 18, 3, 16));
    add_entry("op", r_type('h00, 1, 19, 16, 17));
    add_entry("op", r_type('h00, 5, 20, 3, 9));
    add_entry("op", r_type('h20, 5, 21, 3, 10));
    add_entry("fwd", i_type('h13, 0, 22, 0, 100));
    add_entry("fwd", i_type('h13, 0, 23, 0, 7));
    add_entry("fwd", r_type('h00, 0, 24, 22, 23));
    add_entry("fwd", i_type('h13, 0, 25, 0, 3));
    add_entry("fwd", i_type('h13, 0, 26, 0, 4));
    add_entry("fwd", i_type('h13, 0, 27, 0, 5));
    add_entry("fwd", r_type('h00, 0, 28, 25, 24));
    add_entry("fwd", r_type('h20, 0, 29, 26, 28));
    add_entry("x0", i_type('h13, 0, 0, 0, 55));
    add_entry("x0", i_type('h13, 0, 30, 0, 9));
    add_entry("x0", r_type('h00, 0, 0, 1, 3));
    add_entry("x0", r_type('h00, 0, 31, 0, 0));
    add_entry("mem", i_type('h13, 0, 1, 0, 'h40));
    add_entry("mem", i_type('h13, 0, 2, 0, 'h7a));
    add_entry("mem", s_type(2, 1, 0));
    add_entry("mem", s_type(3, 1, 4));
    add_entry("mem", i_type('h03, 2, 4, 1, 0));
    add_entry("mem", i_type('h03, 2, 5, 1, 4));
    add_entry("mem", i_type('h13, 0, 6, 5, 1));
    add_entry("mem", i_type('h03, 2, 7, 1, 0));
    add_entry("mem", r_type('h00, 0, 8, 7, 7));
    add_entry("mem", s_type(8, 1, 8));
    add_entry("mem", i_type('h03, 2, 9, 1, 8));
    add_entry("mem", s_type(9, 1, 12));
    add_entry("mem", i_type('h03, 2, 10, 1, 12));
    // Small register window so random entries depend on each other
    for (int n = 0; n < 40; n++) begin
        kind = rand_bits(3);
        rd   = rand_bits(3);
        rs1  = rand_bits(3);
        rs2  = rand_bits(3);
        f3   = rand_bits(3);
        imm  = rand_bits(12);
        alt  = rand_bits(1);
        case (kind)
            0: add_entry("random", u_type('h37, rd, rand_bits(20)));
            1: add_entry("random", u_type('h17, rd, rand_bits(20)));
            3, 4: begin
                if (f3 == 1)
                    imm = imm & 'h1f;
                else if (f3 == 5)
                    imm = (imm & 'h1f) | (alt << 10);
                add_entry("random", i_type('h13, f3, rd, rs1, imm));
            end
            5: add_entry("random", i_type('h03, 2, rd, 0, (imm & 7) << 2));
            6: add_entry("random", s_type(rs2, 0, (imm & 7) << 2));
            default: begin
                if (f3 != 0 && f3 != 5)
                    alt = 0;
                add_entry("random", r_type(alt << 5, f3, rd, rs1, rs2));
            end
        endcase
    end
endtask

// Present one entry and hold it until decode takes it
task automatic issue_entry(input logic [31:0] ins);
    logic expect_hz;
    expect_hz = reads_reg(ins, load_rd);
    @(negedge clk_i);
    instr_i = ins;
    pc_i    = pc;
    #1;
    if (hazard_o !== expect_hz) begin
        $display("** Error hazard_o: expected %h, got %h (instr %h)", expect_hz, hazard_o, ins);
        error_count++;
        test_errors++;
    end
    while (hazard_o) begin
        @(negedge clk_i);
        #1;
        if (hazard_o) begin
            $display("hazard_o stayed high for more than one cycle on instr %h", ins);
            error_count++;
            test_errors++;
        end
    end
    model_exec(ins, pc);
    load_rd = (ins[6:0] == 7'h03) ? ins[11:7] : 5'd0;
    pc = pc + 32'd4;
endtask

// Give the last write-backs a few cycles to arrive
task automatic drain_pipeline();
    int waited;
    waited = 0;
    while (exp_addr.size() != 0 && waited < 8) begin
        @(negedge clk_i);
        // addi x0, x0, 0
        instr_i = 32'h0000_0013;
        waited++;
    end
    load_rd = 5'd0;
endtask

always @(negedge clk_i) begin
    if (!rst_i && wb_we_o === 1'b1) begin
        if (exp_addr.size() == 0) begin
            $display("Write-back to x%0d arrived with no instruction pending", wb_addr_o);
            error_count++;
            test_errors++;
        end else begin
            if (wb_addr_o !== exp_addr[0]) begin
                $display("** Error wb_addr_o: expected %h, got %h", exp_addr[0], wb_addr_o);
                error_count++;
                test_errors++;
            end
            if (wb_data_o !== exp_data[0]) begin
                $display("** Error wb_data_o: expected %h, got %h", exp_data[0], wb_data_o);
                error_count++;
                test_errors++;
            end
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
            check_count++;
            test_checks++;
        end
    end
end

always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
        $display("Timeout after %0d cycles", cycle_count);
        $display("Simulation FAILED");
        $finish;
    end
end

initial begin
    rst_i   = 1'b1;
    instr_i = 32'h0000_0013;
    pc_i    = '0;
    pc      = 32'h0000_1000;
    load_rd = 5'd0;
    for (int i = 0; i < 32; i++)
        model_regs[i] = '0;
    for (int i = 0; i < 64; i++)
        model_mem[i] = '0;
    build_program();
    cycle_limit = 3 * prog.size() + 40;

    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    for (int idx = 0; idx < prog.size(); idx++) begin
        issue_entry(prog[idx]);
        if (idx == prog.size() - 1 || entry_name[idx + 1] != entry_name[idx]) begin
            drain_pipeline();
            $display("test %s: %0d write-backs checked, %0d errors",
                     entry_name[idx], test_checks, test_errors);
            test_checks = 0;
            test_errors = 0;
        end
    end

    repeat (4) @(negedge clk_i);
    if (exp_addr.size() != 0) begin
        $display("%0d expected write-backs never arrived", exp_addr.size());
        error_count++;
    end
    $display("Checks: %0d, errors: %0d, cycles: %0d", check_count, error_count, cycle_count);
    if (error_count == 0)
        $display("Simulation PASSED");
    else
        $display("Simulation FAILED");
    $finish;
end

endmodule

// File: tb.f
src/core_pkg.sv
src/instr_decoder.sv
src/bypass_controller.sv
src/decode_stage.sv
src/execute_stage.sv
src/result_stage.sv
src/reg_file.sv
src/core_slice.sv
verif/core_slice_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and decide the result from the simulation output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module core_slice_tb -f tb.f -o core_slice_sim &&
    ./obj_dir/core_slice_sim | tee /dev/stderr | grep -q "Simulation PASSED" &&
    echo "run.sh: pass" ||
    { echo "run.sh: fail"; exit 1; }
